//--- verilog/rvPkg.sv
package rvPkg;

    localparam int XLEN     = 32;    // integer register and datapath width
    localparam int REGADDRW = 5;     // x0..x31

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,   // loads, not implemented
        STORE  = 5'b01000,   // stores, not implemented
        OP_IMM = 5'b00100,   // register-immediate ALU ops
        OP     = 5'b01100,   // register-register ALU ops
        LUI    = 5'b01101,   // load upper immediate
        AUIPC  = 5'b00101,   // needs a pc, not implemented
        BRANCH = 5'b11000,   // conditional branches, not implemented
        JAL    = 5'b11011,   // jump and link, not implemented
        JALR   = 5'b11001,   // jump and link register, not implemented
        SYSTEM = 5'b11100    // ecall / ebreak / csr, not implemented
    } opcodeE;

    // decoded ALU operation, one per distinct datapath function
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,    // signed compare
        SLTU  = 4'd4,    // unsigned compare
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,    // sign bit fills vacated bits
        OR    = 4'd8,
        AND   = 4'd9,
        PASSB = 4'd10    // operand b straight through, for lui
    } aluOpE;

    // funct3 field of OP and OP_IMM, instruction bits 14:12
    typedef enum logic [2:0] {
        F3ADD  = 3'b000,   // add / sub
        F3SLL  = 3'b001,
        F3SLT  = 3'b010,
        F3SLTU = 3'b011,
        F3XOR  = 3'b100,
        F3SRLA = 3'b101,   // srl / sra, picked by instr[30]
        F3OR   = 3'b110,
        F3AND  = 3'b111
    } funct3E;

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    input  logic [31:0]                   instr,
    output logic [rvPkg::REGADDRW-1:0]    rs1Addr,
    output logic [rvPkg::REGADDRW-1:0]    rs2Addr,
    input  logic [rvPkg::XLEN-1:0]        rs1Data,
    input  logic [rvPkg::XLEN-1:0]        rs2Data,
    input  logic                          exWe,
    input  logic [rvPkg::REGADDRW-1:0]    exRd,
    input  logic [rvPkg::XLEN-1:0]        exResult,
    output logic                          dValid,
    output logic                          dWe,
    output logic                          dIllegal,
    output rvPkg::aluOpE                  dAluOp,
    output logic [rvPkg::XLEN-1:0]        dOpA,
    output logic [rvPkg::XLEN-1:0]        dOpB,
    output logic [rvPkg::REGADDRW-1:0]    dRd
);
    import rvPkg::*;

    opcodeE              opcode;
    funct3E              funct3;
    logic [6:0]          funct7;
    logic [REGADDRW-1:0] rd, rs1, rs2;
    logic [XLEN-1:0]     imm;
    logic                bImm;       // operand b comes from the immediate
    logic                supported;
    aluOpE               aluOp;
    logic [XLEN-1:0]     opAReg, opBReg;
    logic [REGADDRW-1:0] dRs1, dRs2;
    logic                dBImm;

    assign opcode = opcodeE'(instr[6:2]);
    assign rd     = instr[11:7];
    assign funct3 = funct3E'(instr[14:12]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign rs1Addr = rs1;   // register file read, combinational
    assign rs2Addr = rs2;

    always_comb begin
        case (opcode)
            OP, OP_IMM, LUI:                               supported = 1'b1;
            LOAD, STORE, AUIPC, BRANCH, JAL, JALR, SYSTEM: supported = 1'b0;
            default:                                       supported = 1'b0;
        endcase
    end

    always_comb begin
        aluOp = ADD;
        case (funct3)
            F3ADD:  if (opcode == OP && funct7[5]) aluOp = SUB;   // no subi in rv32i
            F3SLL:  aluOp = SLL;
            F3SLT:  aluOp = SLT;
            F3SLTU: aluOp = SLTU;
            F3XOR:  aluOp = XOR;
            F3SRLA: aluOp = funct7[5] ? SRA : SRL;   // also srai, imm[10] is bit 30
            F3OR:   aluOp = OR;
            F3AND:  aluOp = AND;
        endcase
        if (opcode == LUI) aluOp = PASSB;
    end

    assign bImm = (opcode == OP_IMM) || (opcode == LUI);
    assign imm  = (opcode == LUI) ? {instr[31:12], 12'b0}
                                  : {{(XLEN-12){instr[31]}}, instr[31:20]};   // sign-extended i-imm

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dValid   <= 1'b0;
            dWe      <= 1'b0;
            dIllegal <= 1'b0;
        end else begin
            dValid   <= instrValid;
            dWe      <= instrValid && supported && (rd != '0);   // x0 writes dropped here only
            dIllegal <= instrValid && !supported;
        end
    end

    always_ff @(posedge clk) begin
        dAluOp <= aluOp;
        opAReg <= rs1Data;   // already write-through for the instruction two ahead
        opBReg <= bImm ? imm : rs2Data;
        dRd    <= rd;
        dRs1   <= rs1;
        dRs2   <= rs2;
        dBImm  <= bImm;
    end

    // exResult belongs to the instruction just ahead, so its forward is applied late
    assign dOpA = (exWe && exRd == dRs1) ? exResult : opAReg;
    assign dOpB = (!dBImm && exWe && exRd == dRs2) ? exResult : opBReg;

    assert property (@(posedge clk) disable iff (!rstN) !(dIllegal && dWe))
        else $error("decoder flagged an instruction both illegal and writing");

endmodule

//--- verilog/aluExecute.sv
`timescale 1ns/1ns

module aluExecute (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          dValid,
    input  logic                          dWe,
    input  logic                          dIllegal,
    input  rvPkg::aluOpE                  dAluOp,
    input  logic [rvPkg::XLEN-1:0]        dOpA,
    input  logic [rvPkg::XLEN-1:0]        dOpB,
    input  logic [rvPkg::REGADDRW-1:0]    dRd,
    output logic                          exValid,
    output logic                          exWe,
    output logic                          exIllegal,
    output logic [rvPkg::REGADDRW-1:0]    exRd,
    output logic [rvPkg::XLEN-1:0]        exResult
);
    import rvPkg::*;

    logic [$clog2(XLEN)-1:0] shamt;
    logic [XLEN-1:0]         aluRes;
    logic                    ltSigned, ltUnsigned;

    assign shamt      = dOpB[$clog2(XLEN)-1:0];   // only low 5 bits count
    assign ltSigned   = $signed(dOpA) < $signed(dOpB);
    assign ltUnsigned = dOpA < dOpB;

    always_comb begin
        case (dAluOp)
            ADD:     aluRes = dOpA + dOpB;
            SUB:     aluRes = dOpA - dOpB;
            SLL:     aluRes = dOpA << shamt;
            SLT:     aluRes = {{(XLEN-1){1'b0}}, ltSigned};
            SLTU:    aluRes = {{(XLEN-1){1'b0}}, ltUnsigned};
            XOR:     aluRes = dOpA ^ dOpB;
            SRL:     aluRes = dOpA >> shamt;
            SRA:     aluRes = $signed(dOpA) >>> shamt;   // copies bit 31
            OR:      aluRes = dOpA | dOpB;
            AND:     aluRes = dOpA & dOpB;
            PASSB:   aluRes = dOpB;   // lui, immediate already shifted
            default: aluRes = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid   <= 1'b0;
            exWe      <= 1'b0;
            exIllegal <= 1'b0;
        end else begin
            exValid   <= dValid;
            exWe      <= dWe;
            exIllegal <= dIllegal;
        end
    end

    always_ff @(posedge clk) begin
        exRd     <= dRd;
        exResult <= aluRes;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        dValid |-> !$isunknown(dAluOp) &&
                   dAluOp inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB})
        else $error("execute received an undefined ALU operation");

endmodule

//--- verilog/regFileWriteback.sv
`timescale 1ns/1ns

module regFileWriteback (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [rvPkg::REGADDRW-1:0]    rs1Addr,
    input  logic [rvPkg::REGADDRW-1:0]    rs2Addr,
    output logic [rvPkg::XLEN-1:0]        rs1Data,
    output logic [rvPkg::XLEN-1:0]        rs2Data,
    input  logic                          exValid,
    input  logic                          exWe,
    input  logic                          exIllegal,
    input  logic [rvPkg::REGADDRW-1:0]    exRd,
    input  logic [rvPkg::XLEN-1:0]        exResult,
    output logic                          wbValid,
    output logic [rvPkg::REGADDRW-1:0]    wbAddr,
    output logic [rvPkg::XLEN-1:0]        wbData,
    output logic                          illegal
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [1:2**REGADDRW-1];   // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 2**REGADDRW; i++) begin
                regs[i] <= '0;
            end
        end else if (exWe) begin
            regs[exRd] <= exResult;
        end
    end

    // x0 reads zero, a write landing this cycle wins over the array
    assign rs1Data = (rs1Addr == '0)              ? '0 :
                     (exWe && exRd == rs1Addr)    ? exResult : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0)              ? '0 :
                     (exWe && exRd == rs2Addr)    ? exResult : regs[rs2Addr];

    assign wbValid = exValid && exWe;   // one pulse per register write
    assign wbAddr  = exRd;
    assign wbData  = exResult;
    assign illegal = exValid && exIllegal;

    assert property (@(posedge clk) disable iff (!rstN) exWe |-> exRd != '0)
        else $error("register write aimed at x0");

endmodule

//--- verilog/rvCore.sv
`timescale 1ns/1ns

module rvCore (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    input  logic [31:0]                   instr,
    output logic                          wbValid,
    output logic [rvPkg::REGADDRW-1:0]    wbAddr,
    output logic [rvPkg::XLEN-1:0]        wbData,
    output logic                          illegal
);
    import rvPkg::*;

    logic [REGADDRW-1:0] rs1Addr, rs2Addr;   // decode to register file
    logic [XLEN-1:0]     rs1Data, rs2Data;

    logic                dValid, dWe, dIllegal;   // decode to execute
    aluOpE               dAluOp;
    logic [XLEN-1:0]     dOpA, dOpB;
    logic [REGADDRW-1:0] dRd;

    logic                exValid, exWe, exIllegal;   // execute to result, also forwarded
    logic [REGADDRW-1:0] exRd;
    logic [XLEN-1:0]     exResult;

    instrDecoder i_instrDecoder (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .exWe       (exWe),
        .exRd       (exRd),
        .exResult   (exResult),
        .dValid     (dValid),
        .dWe        (dWe),
        .dIllegal   (dIllegal),
        .dAluOp     (dAluOp),
        .dOpA       (dOpA),
        .dOpB       (dOpB),
        .dRd        (dRd)
    );

    aluExecute i_aluExecute (
        .clk       (clk),
        .rstN      (rstN),
        .dValid    (dValid),
        .dWe       (dWe),
        .dIllegal  (dIllegal),
        .dAluOp    (dAluOp),
        .dOpA      (dOpA),
        .dOpB      (dOpB),
        .dRd       (dRd),
        .exValid   (exValid),
        .exWe      (exWe),
        .exIllegal (exIllegal),
        .exRd      (exRd),
        .exResult  (exResult)
    );

    regFileWriteback i_regFileWriteback (
        .clk       (clk),
        .rstN      (rstN),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .exValid   (exValid),
        .exWe      (exWe),
        .exIllegal (exIllegal),
        .exRd      (exRd),
        .exResult  (exResult),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .illegal   (illegal)
    );

endmodule

//--- tb/rvCoreChecker.sv
`timescale 1ns/1ns

module rvCoreChecker (
    input logic                       clk,
    input logic                       rstN,
    input logic                       wbValid,
    input logic [rvPkg::REGADDRW-1:0] wbAddr,
    input logic [rvPkg::XLEN-1:0]     wbData,
    input logic                       illegal
);

    string                      expName [$];
    string                      expKind [$];
    logic [rvPkg::REGADDRW-1:0] expRd [$];
    logic [rvPkg::XLEN-1:0]     expData [$];
    int                         expDue [$];   // cycle whose edge samples the slot
    int                         cycle     = 0;
    int                         passCount = 0;
    int                         failCount = 0;

    task automatic pushExpected(input string name, input string kind,
                                input logic [rvPkg::REGADDRW-1:0] rd,
                                input logic [rvPkg::XLEN-1:0] data);
        expName.push_back(name);
        expKind.push_back(kind);
        expRd.push_back(rd);
        expData.push_back(data);
        expDue.push_back(cycle + 3);   // accepted next edge, then two stages
    endtask

    function automatic int pendingCount();
        return expDue.size();
    endfunction

    // oldest entry against what the DUT shows in its slot
    task automatic judgeOldest();
        string                      name;
        string                      kind;
        logic [rvPkg::REGADDRW-1:0] rd;
        logic [rvPkg::XLEN-1:0]     data;
        name = expName.pop_front();
        kind = expKind.pop_front();
        rd   = expRd.pop_front();
        data = expData.pop_front();
        expDue.delete(0);
        if (kind == "W" && (wbValid !== 1'b1 || illegal !== 1'b0)) begin
            $display("%s: expected a write to x%0d, got wbValid=%b illegal=%b",
                     name, rd, wbValid, illegal);
            failCount++;
        end else if (kind == "W" && (wbAddr !== rd || wbData !== data)) begin
            $display("CHECK FAILED %s expected x%0d=%h actual x%0d=%h",
                     name, rd, data, wbAddr, wbData);
            failCount++;
        end else if (kind == "I" && (illegal !== 1'b1 || wbValid !== 1'b0)) begin
            $display("%s: expected one illegal pulse and no write, got wbValid=%b illegal=%b",
                     name, wbValid, illegal);
            failCount++;
        end else if (kind == "N" && (wbValid !== 1'b0 || illegal !== 1'b0)) begin
            $display("%s: expected no output, got wbValid=%b illegal=%b", name, wbValid, illegal);
            failCount++;
        end else if (kind != "W" && kind != "I" && kind != "N") begin
            $display("%s: unknown expected kind %s in the vectors", name, kind);
            failCount++;
        end else begin
            $display("PASS %s", name);
            passCount++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rstN) begin
            if (expDue.size() > 0 && expDue[0] == cycle) begin
                judgeOldest();
            end else if (wbValid !== 1'b0 || illegal !== 1'b0) begin
                $display("output pulse with no pending test at cycle %0d, wbValid=%b illegal=%b",
                         cycle, wbValid, illegal);
                failCount++;
            end
        end
    end

endmodule

//--- tb/rvCoreTb.sv
`timescale 1ns/1ns

module rvCoreTb;

    localparam int CLKPERIOD = 40;
    localparam int MAXVEC    = 64;
    localparam int DRIVEDLY  = 2;    // ns after the rising edge

    logic                       clk;
    logic                       rstN;
    logic                       instrValid;
    logic [31:0]                instr;
    logic                       wbValid;
    logic [rvPkg::REGADDRW-1:0] wbAddr;
    logic [rvPkg::XLEN-1:0]     wbData;
    logic                       illegal;

    string                      vecName [MAXVEC];
    logic [31:0]                vecInstr [MAXVEC];
    string                      vecKind [MAXVEC];
    logic [rvPkg::REGADDRW-1:0] vecRd [MAXVEC];
    logic [rvPkg::XLEN-1:0]     vecData [MAXVEC];
    int                         numVec = 0;

    rvCore i_rvCore (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .illegal    (illegal)
    );

    rvCoreChecker outputCheck (
        .clk     (clk),
        .rstN    (rstN),
        .wbValid (wbValid),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .illegal (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLKPERIOD/2) clk = ~clk;
    end

    task automatic loadVectors();
        int                         fd;
        string                      line;
        string                      name;
        string                      kind;
        logic [31:0]                word;
        logic [rvPkg::REGADDRW-1:0] rd;
        logic [rvPkg::XLEN-1:0]     data;
        fd = $fopen("tb/coreVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/coreVectors.txt, no tests loaded");
        end else begin
            while (!$feof(fd) && numVec < MAXVEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%s %h %s %d %h", name, word, kind, rd, data) == 5) begin
                    vecName[numVec]  = name;
                    vecInstr[numVec] = word;
                    vecKind[numVec]  = kind;
                    vecRd[numVec]    = rd;
                    vecData[numVec]  = data;
                    numVec++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        loadVectors();
        repeat (3) @(posedge clk);
        #DRIVEDLY rstN = 1'b1;
        repeat (3) @(posedge clk);   // quiet after reset, checker flags any pulse
        for (int i = 0; i < numVec; i++) begin
            @(posedge clk);
            #DRIVEDLY;
            instrValid = 1'b1;
            instr      = vecInstr[i];
            outputCheck.pushExpected(vecName[i], vecKind[i], vecRd[i], vecData[i]);
            if (i % 8 == 7) begin
                @(posedge clk);
                #DRIVEDLY instrValid = 1'b0;   // occasional bubble
            end
        end
        @(posedge clk);
        #DRIVEDLY instrValid = 1'b0;
        while (outputCheck.pendingCount() != 0) @(posedge clk);
        repeat (4) @(posedge clk);   // room for stray pulses
        $display("%0d tests passed, %0d failed", outputCheck.passCount, outputCheck.failCount);
        if (numVec > 0 && outputCheck.failCount == 0 && outputCheck.passCount == numVec) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog, sized from the vector count
    initial begin
        wait (rstN === 1'b1);
        repeat (numVec * 4 + 50) @(posedge clk);
        $display("timeout after %0d clock periods, results still outstanding", numVec * 4 + 50);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- tb/coreVectors.txt
# name  instr(hex)  kind(W write, I illegal, N nothing)  rd(dec)  data(hex)
# rd and data are ignored for I and N
luiHigh     800000B7 W 1  80000000
addiNeg     FFB00113 W 2  FFFFFFFB
addiPos     00700193 W 3  00000007
addFwd      00310233 W 4  00000002
subFwd      402182B3 W 5  0000000C
sllFwd      00321333 W 6  00000100
addChain    005303B3 W 7  0000010C
sltMixed    00312433 W 8  00000001
sltuMixed   003134B3 W 9  00000000
sraNeg      4030D533 W 10 FF000000
srlNeg      0030D5B3 W 11 01000000
xorOp       00314633 W 12 FFFFFFFC
orOp        003166B3 W 13 FFFFFFFF
andOp       00317733 W 14 00000003
sltiNeg     FFC12793 W 15 00000001
sltiuAll    FFF1B813 W 16 00000001
xoriNot     FFF1C893 W 17 FFFFFFF8
oriOp       0F01E913 W 18 000000F7
andiOp      0FF17993 W 19 000000FB
slliOp      00419A13 W 20 00000070
sraiNeg     40115A93 W 21 FFFFFFFD
srliOp      01C15B13 W 22 0000000F
addToX0     00318033 N 0  00000000
readX0      00300BB3 W 23 00000007
branchOp    00318063 I 0  00000000
loadOp      0001AC03 I 0  00000000
storeOp     00302023 I 0  00000000
jalOp       00000CEF I 0  00000000
unwritten   019C0D33 W 26 00000000
afterIll    00328DB3 W 27 00000013
luiMid      12345F37 W 30 12345000
addLuiFwd   002F0FB3 W 31 12344FFB

//--- all.f
verilog/rvPkg.sv
verilog/instrDecoder.sv
verilog/aluExecute.sv
verilog/regFileWriteback.sv
verilog/rvCore.sv
tb/rvCoreChecker.sv
tb/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module rvCoreTb -Mdir obj_dir -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rvCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
